/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::xlen_t      pc,
    input  rv_pkg::xlen_t      rs1_data,
    input  rv_pkg::xlen_t      rs2_data,
    input  rv_pkg::xlen_t      imm,
    input  rv_pkg::opnd1_sel_t opnd1_sel,
    input  rv_pkg::opnd2_sel_t opnd2_sel,
    input  rv_pkg::alu_op_t    alu_op,
    input  logic               word_op,
    input  rv_pkg::mem_strb_t  mem_wstrb,
    output rv_pkg::xlen_t      alu_result,
    output rv_pkg::xlen_t      mem_wdata
);
    import rv_pkg::*;

    xlen_t      opnd_a, opnd_b, srl_src, sra_src, raw, wdata_mask;
    logic [5:0] shamt;

    always_comb begin
        case (opnd1_sel)
            OP1_RS1:  opnd_a = rs1_data;
            OP1_PC:   opnd_a = pc;
            OP1_ZERO: opnd_a = '0;
            default:  opnd_a = '0;
        endcase
        case (opnd2_sel)
            OP2_RS2: opnd_b = rs2_data;
            OP2_IMM: opnd_b = imm;
            default: opnd_b = '0;
        endcase
    end

    // word shifts use the low word and a 5-bit amount
    assign shamt   = word_op ? {1'b0, opnd_b[4:0]} : opnd_b[5:0];
    assign srl_src = word_op ? {32'b0, opnd_a[31:0]} : opnd_a;
    assign sra_src = word_op ? {{32{opnd_a[31]}}, opnd_a[31:0]} : opnd_a;

    always_comb begin
        case (alu_op)
            OP_ADD:   raw = opnd_a + opnd_b;
            OP_SUB:   raw = opnd_a - opnd_b;
            OP_SLT:   raw = xlen_t'($signed(opnd_a) < $signed(opnd_b));
            OP_SLTU:  raw = xlen_t'(opnd_a < opnd_b);
            OP_XOR:   raw = opnd_a ^ opnd_b;
            OP_OR:    raw = opnd_a | opnd_b;
            OP_AND:   raw = opnd_a & opnd_b;
            OP_SLL:   raw = opnd_a << shamt;
            OP_SRL:   raw = srl_src >> shamt;
            OP_SRA:   raw = xlen_t'($signed(sra_src) >>> shamt);
            OP_PASSB: raw = opnd_b;
            default:  raw = '0;
        endcase
    end

    assign alu_result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

    ////////////////////
    // store lane alignment
    ////////////////////
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            wdata_mask[8*i +: 8] = {8{mem_wstrb[i]}};
        end
    end

    assign mem_wdata = (rs2_data & wdata_mask) << {alu_result[2:0], 3'b000};

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic              sys_clk,
    input  logic              reset,
    input  rv_pkg::inst_t     inst,
    input  rv_pkg::xlen_t     mem_rdata,
    output rv_pkg::xlen_t     pc,
    output rv_pkg::xlen_t     mem_addr,
    output rv_pkg::xlen_t     mem_wdata,
    output rv_pkg::mem_strb_t mem_wstrb,
    output logic              mem_wen,
    output rv_pkg::mem_strb_t mem_rstrb,
    output logic              mem_rsext,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::xlen_t     wb_data
);
    import rv_pkg::*;

    reg_addr_t  rs1, rs2, rd;
    xlen_t      rs1_data, rs2_data, imm, alu_result;
    logic       reg_wen, dec_mem_wen, word_op;
    npc_sel_t   npc_sel;
    wb_sel_t    wb_sel;
    opnd1_sel_t opnd1_sel;
    opnd2_sel_t opnd2_sel;
    alu_op_t    alu_op;

    ////////////////////
    // decode and registers
    ////////////////////
    rv_decoder i_rv_decoder (
        .inst      (inst),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .reg_wen   (reg_wen),
        .mem_wen   (dec_mem_wen),
        .mem_wstrb (mem_wstrb),
        .mem_rstrb (mem_rstrb),
        .mem_rsext (mem_rsext),
        .npc_sel   (npc_sel),
        .wb_sel    (wb_sel),
        .opnd1_sel (opnd1_sel),
        .opnd2_sel (opnd2_sel),
        .alu_op    (alu_op),
        .word_op   (word_op)
    );

    rv_regfile i_rv_regfile (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wen      (wb_en),
        .rd       (wb_rd),
        .rd_data  (wb_data)
    );

    ////////////////////
    // execute, result, next pc
    ////////////////////
    rv_alu i_rv_alu (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .opnd1_sel  (opnd1_sel),
        .opnd2_sel  (opnd2_sel),
        .alu_op     (alu_op),
        .word_op    (word_op),
        .mem_wstrb  (mem_wstrb),
        .alu_result (alu_result),
        .mem_wdata  (mem_wdata)
    );

    rv_writeback i_rv_writeback (
        .reg_wen    (reg_wen),
        .reset      (reset),
        .rd         (rd),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .mem_rstrb  (mem_rstrb),
        .mem_rsext  (mem_rsext),
        .pc         (pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    rv_pc_unit #(
        .RESET_PC (RESET_PC)
    ) i_rv_pc_unit (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .npc_sel     (npc_sel),
        .imm         (imm),
        .jalr_target (alu_result),
        .pc          (pc)
    );

    // address comes straight from the adder, stores held off in reset
    assign mem_addr = alu_result;
    assign mem_wen  = dec_mem_wen && !reset;

endmodule

`default_nettype wire

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  rv_pkg::inst_t      inst,
    input  rv_pkg::xlen_t      rs1_data,
    input  rv_pkg::xlen_t      rs2_data,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    output rv_pkg::reg_addr_t  rd,
    output rv_pkg::xlen_t      imm,
    output logic               reg_wen,
    output logic               mem_wen,
    output rv_pkg::mem_strb_t  mem_wstrb,
    output rv_pkg::mem_strb_t  mem_rstrb,
    output logic               mem_rsext,
    output rv_pkg::npc_sel_t   npc_sel,
    output rv_pkg::wb_sel_t    wb_sel,
    output rv_pkg::opnd1_sel_t opnd1_sel,
    output rv_pkg::opnd2_sel_t opnd2_sel,
    output rv_pkg::alu_op_t    alu_op,
    output logic               word_op
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [7:0] f3;
    logic       f7_zero, f7_alt, f6_zero, f6_alt;
    logic       ri_ok, ri32_ok, rr_ok, rr32_ok, ri, rr;
    logic       load_ok, store_ok, branch_ok, lui, auipc, jal, jalr_ok;
    logic       eq, lt, ltu, br_taken;
    mem_strb_t  size_strb;

    ////////////////////
    // fields and immediates
    ////////////////////
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // funct3 as one-hot
    assign f3 = 8'b1 << funct3;

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    // rv64 shift immediates borrow funct7[0] for shamt[5]
    assign f6_zero = (funct7[6:1] == 6'b000000);
    assign f6_alt  = (funct7[6:1] == 6'b010000);

    ////////////////////
    // instruction matching
    ////////////////////
    assign ri_ok   = (opcode == OPC_OPIMM) &&
                     (!(f3[1] || f3[5]) || (f3[1] && f6_zero) ||
                      (f3[5] && (f6_zero || f6_alt)));
    assign ri32_ok = (opcode == OPC_OPIMM32) &&
                     (f3[0] || (f3[1] && f7_zero) || (f3[5] && (f7_zero || f7_alt)));
    assign rr_ok   = (opcode == OPC_OP) &&
                     (f7_zero || (f7_alt && (f3[0] || f3[5])));
    assign rr32_ok = (opcode == OPC_OP32) &&
                     ((f7_zero && (f3[0] || f3[1] || f3[5])) ||
                      (f7_alt && (f3[0] || f3[5])));

    assign ri = ri_ok || ri32_ok;
    assign rr = rr_ok || rr32_ok;

    assign load_ok   = (opcode == OPC_LOAD) && !f3[7];
    assign store_ok  = (opcode == OPC_STORE) && !funct3[2];
    assign branch_ok = (opcode == OPC_BRANCH) && !(f3[2] || f3[3]);
    assign lui       = (opcode == OPC_LUI);
    assign auipc     = (opcode == OPC_AUIPC);
    assign jal       = (opcode == OPC_JAL);
    assign jalr_ok   = (opcode == OPC_JALR) && f3[0];

    // sign-extended immediate per format
    assign imm = ({64{ri || load_ok || jalr_ok}} & {{52{inst[31]}}, inst[31:20]})
               | ({64{store_ok}} & {{52{inst[31]}}, inst[31:25], inst[11:7]})
               | ({64{branch_ok}} &
                  {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0})
               | ({64{lui || auipc}} & {{32{inst[31]}}, inst[31:12], 12'b0})
               | ({64{jal}} &
                  {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0});

    ////////////////////
    // control selects
    ////////////////////
    assign reg_wen = ri || rr || load_ok || lui || auipc || jal || jalr_ok;
    assign mem_wen = store_ok;
    assign word_op = ri32_ok || rr32_ok;

    // access size from funct3[1:0], shared by loads and stores
    always_comb begin
        case (funct3[1:0])
            2'b00:   size_strb = 8'b0000_0001;
            2'b01:   size_strb = 8'b0000_0011;
            2'b10:   size_strb = 8'b0000_1111;
            default: size_strb = 8'b1111_1111;
        endcase
    end

    assign mem_wstrb = store_ok ? size_strb : '0;
    assign mem_rstrb = load_ok ? size_strb : '0;
    assign mem_rsext = load_ok && !funct3[2];

    assign wb_sel = (WB_LINK & {3{jal || jalr_ok}})
                  | (WB_MEM  & {3{load_ok}})
                  | (WB_ALU  & {3{ri || rr || lui || auipc}});

    assign opnd1_sel = (OP1_RS1  & {3{ri || rr || load_ok || store_ok || jalr_ok}})
                     | (OP1_PC   & {3{auipc || jal || branch_ok}})
                     | (OP1_ZERO & {3{lui}});

    assign opnd2_sel = (OP2_RS2 & {2{rr}})
                     | (OP2_IMM & {2{ri || load_ok || store_ok || branch_ok ||
                                     jal || jalr_ok || lui || auipc}});

    // inst[30] splits sub from add and sra from srl
    assign alu_op = (OP_ADD  & {11{((ri || (rr && !inst[30])) && f3[0]) || load_ok ||
                                   store_ok || branch_ok || lui || auipc ||
                                   jal || jalr_ok}})
                  | (OP_SUB  & {11{rr && inst[30] && f3[0]}})
                  | (OP_SLT  & {11{(ri || rr) && f3[2]}})
                  | (OP_SLTU & {11{(ri || rr) && f3[3]}})
                  | (OP_XOR  & {11{(ri || rr) && f3[4]}})
                  | (OP_OR   & {11{(ri || rr) && f3[6]}})
                  | (OP_AND  & {11{(ri || rr) && f3[7]}})
                  | (OP_SLL  & {11{(ri || rr) && f3[1]}})
                  | (OP_SRL  & {11{(ri || rr) && f3[5] && !inst[30]}})
                  | (OP_SRA  & {11{(ri || rr) && f3[5] && inst[30]}});

    ////////////////////
    // branch decision
    ////////////////////
    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data);

    assign br_taken = branch_ok && ((f3[0] && eq) || (f3[1] && !eq) ||
                                    (f3[4] && lt) || (f3[5] && !lt) ||
                                    (f3[6] && ltu) || (f3[7] && !ltu));

    assign npc_sel = (NPC_JALR & {4{jalr_ok}})
                   | (NPC_JAL  & {4{jal}})
                   | (NPC_BR   & {4{br_taken}})
                   | (NPC_SEQ  & {4{!(jalr_ok || jal || br_taken)}});

endmodule

`default_nettype wire

/* hdl/rv_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit #(
    parameter rv_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic             sys_clk,
    input  logic             reset,
    input  rv_pkg::npc_sel_t npc_sel,
    input  rv_pkg::xlen_t    imm,
    input  rv_pkg::xlen_t    jalr_target,
    output rv_pkg::xlen_t    pc
);
    import rv_pkg::*;

    xlen_t next_pc;

    always_comb begin
        case (npc_sel)
            NPC_SEQ:         next_pc = pc + xlen_t'(4);
            NPC_BR, NPC_JAL: next_pc = pc + imm;
            // jalr clears bit 0 of the target
            NPC_JALR:        next_pc = jalr_target & ~xlen_t'(1);
            default:         next_pc = pc + xlen_t'(4);
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // data and instruction widths
    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  mem_strb_t;

    // one-hot select vectors
    typedef logic [10:0] alu_op_t;
    typedef logic [2:0]  opnd1_sel_t;
    typedef logic [1:0]  opnd2_sel_t;
    typedef logic [2:0]  wb_sel_t;
    typedef logic [3:0]  npc_sel_t;

    localparam alu_op_t OP_ADD   = 11'b000_0000_0001;
    localparam alu_op_t OP_SUB   = 11'b000_0000_0010;
    localparam alu_op_t OP_SLT   = 11'b000_0000_0100;
    localparam alu_op_t OP_SLTU  = 11'b000_0000_1000;
    localparam alu_op_t OP_XOR   = 11'b000_0001_0000;
    localparam alu_op_t OP_OR    = 11'b000_0010_0000;
    localparam alu_op_t OP_AND   = 11'b000_0100_0000;
    localparam alu_op_t OP_SLL   = 11'b000_1000_0000;
    localparam alu_op_t OP_SRL   = 11'b001_0000_0000;
    localparam alu_op_t OP_SRA   = 11'b010_0000_0000;
    localparam alu_op_t OP_PASSB = 11'b100_0000_0000;

    localparam opnd1_sel_t OP1_RS1  = 3'b001;
    localparam opnd1_sel_t OP1_PC   = 3'b010;
    localparam opnd1_sel_t OP1_ZERO = 3'b100;

    localparam opnd2_sel_t OP2_RS2 = 2'b01;
    localparam opnd2_sel_t OP2_IMM = 2'b10;

    localparam wb_sel_t WB_ALU  = 3'b001;
    localparam wb_sel_t WB_MEM  = 3'b010;
    localparam wb_sel_t WB_LINK = 3'b100;

    localparam npc_sel_t NPC_SEQ  = 4'b0001;
    localparam npc_sel_t NPC_BR   = 4'b0010;
    localparam npc_sel_t NPC_JAL  = 4'b0100;
    localparam npc_sel_t NPC_JALR = 4'b1000;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;

endpackage

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic              sys_clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data,
    input  logic              wen,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::xlen_t     rd_data
);
    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hdl/rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
    input  logic              reg_wen,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::wb_sel_t   wb_sel,
    input  rv_pkg::xlen_t     alu_result,
    input  rv_pkg::xlen_t     mem_rdata,
    input  rv_pkg::mem_strb_t mem_rstrb,
    input  logic              mem_rsext,
    input  rv_pkg::xlen_t     pc,
    output logic              wb_en,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::xlen_t     wb_data
);
    import rv_pkg::*;

    xlen_t rdata_low, rdata_mask, load_val;
    logic  sign_bit;

    // bring the addressed byte lane down to bit 0
    assign rdata_low = mem_rdata >> {alu_result[2:0], 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            rdata_mask[8*i +: 8] = {8{mem_rstrb[i]}};
        end
        // top bit of the access width
        if (mem_rstrb[7]) begin
            sign_bit = rdata_low[63];
        end else if (mem_rstrb[3]) begin
            sign_bit = rdata_low[31];
        end else if (mem_rstrb[1]) begin
            sign_bit = rdata_low[15];
        end else begin
            sign_bit = rdata_low[7];
        end
    end

    assign load_val = (rdata_low & rdata_mask) |
                      (~rdata_mask & {64{mem_rsext && sign_bit}});

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_data = alu_result;
            WB_MEM:  wb_data = load_val;
            WB_LINK: wb_data = pc + xlen_t'(4);
            default: wb_data = '0;
        endcase
    end

    assign wb_en = reg_wen && !reset;
    assign wb_rd = rd;

endmodule

`default_nettype wire

/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_writeback.sv
hdl/rv_pc_unit.sv
hdl/rv_core.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

/* test/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
    input logic          sys_clk,
    input logic          reset,
    input logic          mem_wen,
    input logic          wb_en,
    input rv_pkg::xlen_t pc
);
    int assert_fails = 0;

    // no memory write while in reset
    no_store_in_reset: assert property (@(posedge sys_clk) reset |-> !mem_wen)
        else begin
            assert_fails++;
            $error("mem_wen high while reset is high");
        end

    // no register retire while in reset
    no_retire_in_reset: assert property (@(posedge sys_clk) reset |-> !wb_en)
        else begin
            assert_fails++;
            $error("wb_en high while reset is high");
        end

    // instruction fetch stays word aligned
    pc_word_aligned: assert property (@(posedge sys_clk) disable iff (reset)
        pc[1:0] == 2'b00)
        else begin
            assert_fails++;
            $error("pc not word aligned");
        end

endmodule

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam logic [63:0] RESET_PC = 64'h8000_0000;
    localparam int MAX_STEPS = 64;

    logic        sys_clk = 1'b0;
    logic        reset;
    logic [31:0] inst;
    logic [63:0] mem_rdata;
    logic [63:0] pc, mem_addr, mem_wdata, wb_data;
    logic [7:0]  mem_wstrb, mem_rstrb;
    logic        mem_wen, mem_rsext, wb_en;
    logic [4:0]  wb_rd;

    // program table, one row per executed step
    logic [31:0] prog_inst  [MAX_STEPS];
    logic [63:0] prog_pc    [MAX_STEPS];
    logic        prog_wen   [MAX_STEPS];
    logic [4:0]  prog_rd    [MAX_STEPS];
    logic [63:0] prog_data  [MAX_STEPS];
    logic [7:0]  prog_strb  [MAX_STEPS];
    logic [7:0]  prog_rstrb [MAX_STEPS];
    logic        prog_rsext [MAX_STEPS];
    int          num_steps;

    logic [7:0]  data_mem [64];
    logic [5:0]  rd_base;
    int          seed;
    int          error_count;
    logic        timed_out;

    always #4 sys_clk = ~sys_clk;

    rv_core i_rv_core (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_wen   (mem_wen),
        .mem_rstrb (mem_rstrb),
        .mem_rsext (mem_rsext),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    bind rv_core rv_core_checker i_rv_core_checker (
        .sys_clk (sys_clk),
        .reset   (reset),
        .mem_wen (mem_wen),
        .wb_en   (wb_en),
        .pc      (pc)
    );

    ////////////////////
    // data memory model
    ////////////////////
    // aligned doubleword around mem_addr
    assign rd_base   = {mem_addr[5:3], 3'b000};
    assign mem_rdata = {data_mem[rd_base + 6'd7], data_mem[rd_base + 6'd6],
                        data_mem[rd_base + 6'd5], data_mem[rd_base + 6'd4],
                        data_mem[rd_base + 6'd3], data_mem[rd_base + 6'd2],
                        data_mem[rd_base + 6'd1], data_mem[rd_base]};

    // strobe bit k covers byte mem_addr + k and its data sits in its lane
    always @(posedge sys_clk) begin
        if (mem_wen) begin
            for (int k = 0; k < 8; k++) begin
                if (mem_wstrb[k] && (mem_addr[2:0] + k < 8)) begin
                    data_mem[mem_addr[5:0] + k] <= mem_wdata[8 * (mem_addr[2:0] + k) +: 8];
                end
            end
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic add_step(input logic [31:0] word, input logic [63:0] exp_pc,
                            input logic exp_wen, input logic [4:0] exp_rd,
                            input logic [63:0] exp_data, input logic [7:0] exp_strb);
        prog_inst[num_steps]  = word;
        prog_pc[num_steps]    = exp_pc;
        prog_wen[num_steps]   = exp_wen;
        prog_rd[num_steps]    = exp_rd;
        prog_data[num_steps]  = exp_data;
        prog_strb[num_steps]  = exp_strb;
        prog_rstrb[num_steps] = 8'h00;
        prog_rsext[num_steps] = 1'b0;
        num_steps++;
    endtask

    // read strobe and sign extension of the step just added
    task automatic expect_load(input logic [7:0] exp_rstrb, input logic exp_rsext);
        prog_rstrb[num_steps - 1] = exp_rstrb;
        prog_rsext[num_steps - 1] = exp_rsext;
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error: %0t ns %s: got %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_step(input int s);
        check_value(pc, prog_pc[s], $sformatf("step %0d pc", s));
        check_value(wb_en, prog_wen[s], $sformatf("step %0d wb_en", s));
        check_value(mem_wen, prog_strb[s] != 8'h00, $sformatf("step %0d mem_wen", s));
        check_value(mem_wstrb, prog_strb[s], $sformatf("step %0d mem_wstrb", s));
        check_value(mem_rstrb, prog_rstrb[s], $sformatf("step %0d mem_rstrb", s));
        check_value(mem_rsext, prog_rsext[s], $sformatf("step %0d mem_rsext", s));
        if (prog_wen[s]) begin
            check_value(wb_rd, prog_rd[s], $sformatf("step %0d wb_rd", s));
            check_value(wb_data, prog_data[s], $sformatf("step %0d wb_data", s));
        end
    endtask

    task automatic wait_reset_pc();
        int cycles;
        cycles = 0;
        while (pc !== RESET_PC && cycles < 10) begin
            @(negedge sys_clk);
            cycles++;
        end
        if (pc !== RESET_PC) begin
            $display("timeout: pc never reached the reset address");
            timed_out = 1'b1;
        end
    endtask

    task automatic load_program();
        num_steps = 0;
        // addi x1, addi x2, lui x3, auipc x4
        add_step(32'hffb0_0093, 64'h8000_0000, 1'b1, 5'd1, 64'hffff_ffff_ffff_fffb, 8'h00);
        add_step(32'h1230_0113, 64'h8000_0004, 1'b1, 5'd2, 64'h0000_0000_0000_0123, 8'h00);
        add_step(32'h8765_41b7, 64'h8000_0008, 1'b1, 5'd3, 64'hffff_ffff_8765_4000, 8'h00);
        add_step(32'h0000_1217, 64'h8000_000c, 1'b1, 5'd4, 64'h0000_0000_8000_100c, 8'h00);
        // add, sub, slt, sltu, xor, or, and
        add_step(32'h0020_82b3, 64'h8000_0010, 1'b1, 5'd5, 64'h0000_0000_0000_011e, 8'h00);
        add_step(32'h4011_0333, 64'h8000_0014, 1'b1, 5'd6, 64'h0000_0000_0000_0128, 8'h00);
        add_step(32'h0020_a3b3, 64'h8000_0018, 1'b1, 5'd7, 64'h0000_0000_0000_0001, 8'h00);
        add_step(32'h0020_b433, 64'h8000_001c, 1'b1, 5'd8, 64'h0000_0000_0000_0000, 8'h00);
        add_step(32'h0030_c4b3, 64'h8000_0020, 1'b1, 5'd9, 64'h0000_0000_789a_bffb, 8'h00);
        add_step(32'h0041_6533, 64'h8000_0024, 1'b1, 5'd10, 64'h0000_0000_8000_112f, 8'h00);
        add_step(32'h00a4_f5b3, 64'h8000_0028, 1'b1, 5'd11, 64'h0000_0000_0000_112b, 8'h00);
        // slli 40, srai 4, srli 60
        add_step(32'h0281_1613, 64'h8000_002c, 1'b1, 5'd12, 64'h0001_2300_0000_0000, 8'h00);
        add_step(32'h4041_d693, 64'h8000_0030, 1'b1, 5'd13, 64'hffff_ffff_f876_5400, 8'h00);
        add_step(32'h03c0_d713, 64'h8000_0034, 1'b1, 5'd14, 64'h0000_0000_0000_000f, 8'h00);
        // addw, sllw, sraw with sign extension of the low word
        add_step(32'h0041_07bb, 64'h8000_0038, 1'b1, 5'd15, 64'hffff_ffff_8000_112f, 8'h00);
        add_step(32'h00e4_983b, 64'h8000_003c, 1'b1, 5'd16, 64'h0000_0000_5ffd_8000, 8'h00);
        add_step(32'h40e7_d8bb, 64'h8000_0040, 1'b1, 5'd17, 64'hffff_ffff_ffff_0000, 8'h00);
        // addi to x0 is dropped and add x18 reads x0 as zero
        add_step(32'h0050_0013, 64'h8000_0044, 1'b1, 5'd0, 64'h0000_0000_0000_0005, 8'h00);
        add_step(32'h0020_0933, 64'h8000_0048, 1'b1, 5'd18, 64'h0000_0000_0000_0123, 8'h00);
        // sd 0, sw 8, sh 18, sb 21
        add_step(32'h00f0_3023, 64'h8000_004c, 1'b0, 5'd0, 64'h0, 8'hff);
        add_step(32'h0090_2423, 64'h8000_0050, 1'b0, 5'd0, 64'h0, 8'h0f);
        add_step(32'h0010_1923, 64'h8000_0054, 1'b0, 5'd0, 64'h0, 8'h03);
        add_step(32'h0090_0aa3, 64'h8000_0058, 1'b0, 5'd0, 64'h0, 8'h01);
        // ld, lw, lwu, lh, lhu, lb, lbu, lw back from the stored bytes
        add_step(32'h0000_3983, 64'h8000_005c, 1'b1, 5'd19, 64'hffff_ffff_8000_112f, 8'h00);
        expect_load(8'hff, 1'b1);
        add_step(32'h0000_2a03, 64'h8000_0060, 1'b1, 5'd20, 64'hffff_ffff_8000_112f, 8'h00);
        expect_load(8'h0f, 1'b1);
        add_step(32'h0000_6a83, 64'h8000_0064, 1'b1, 5'd21, 64'h0000_0000_8000_112f, 8'h00);
        expect_load(8'h0f, 1'b0);
        add_step(32'h0120_1b03, 64'h8000_0068, 1'b1, 5'd22, 64'hffff_ffff_ffff_fffb, 8'h00);
        expect_load(8'h03, 1'b1);
        add_step(32'h0120_5b83, 64'h8000_006c, 1'b1, 5'd23, 64'h0000_0000_0000_fffb, 8'h00);
        expect_load(8'h03, 1'b0);
        add_step(32'h0150_0c03, 64'h8000_0070, 1'b1, 5'd24, 64'hffff_ffff_ffff_fffb, 8'h00);
        expect_load(8'h01, 1'b1);
        add_step(32'h0150_4c83, 64'h8000_0074, 1'b1, 5'd25, 64'h0000_0000_0000_00fb, 8'h00);
        expect_load(8'h01, 1'b0);
        add_step(32'h0080_2d03, 64'h8000_0078, 1'b1, 5'd26, 64'h0000_0000_789a_bffb, 8'h00);
        expect_load(8'h0f, 1'b1);
        // beq taken, bne not, blt taken, bgeu not, bgeu taken backward
        add_step(32'h0121_0463, 64'h8000_007c, 1'b0, 5'd0, 64'h0, 8'h00);
        add_step(32'h0121_1463, 64'h8000_0084, 1'b0, 5'd0, 64'h0, 8'h00);
        add_step(32'h0020_c663, 64'h8000_0088, 1'b0, 5'd0, 64'h0, 8'h00);
        add_step(32'h0011_7463, 64'h8000_0094, 1'b0, 5'd0, 64'h0, 8'h00);
        add_step(32'hfe20_fce3, 64'h8000_0098, 1'b0, 5'd0, 64'h0, 8'h00);
        // jal +16, then jalr to x4 + 5 with bit 0 cleared
        add_step(32'h0100_0def, 64'h8000_0090, 1'b1, 5'd27, 64'h0000_0000_8000_0094, 8'h00);
        add_step(32'h0052_0e67, 64'h8000_00a0, 1'b1, 5'd28, 64'h0000_0000_8000_00a4, 8'h00);
        // mul is illegal here so x29 stays zero
        add_step(32'h0220_8eb3, 64'h8000_1010, 1'b0, 5'd0, 64'h0, 8'h00);
        add_step(32'h000d_8f33, 64'h8000_1014, 1'b1, 5'd30, 64'h0000_0000_8000_0094, 8'h00);
        add_step(32'h002e_8fb3, 64'h8000_1018, 1'b1, 5'd31, 64'h0000_0000_0000_0123, 8'h00);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        seed        = 32'hfa10;
        error_count = 0;
        timed_out   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            data_mem[i] = $random(seed);
        end
        load_program();

        // a write and a store in reset must not retire
        reset <= 1'b1;
        inst  <= 32'hffb0_0093;
        for (int c = 0; c < 2; c++) begin
            @(posedge sys_clk);
            inst <= (c == 0) ? 32'h00f0_3023 : 32'hffb0_0093;
            @(negedge sys_clk);
            check_value(wb_en, 1'b0, "wb_en during reset");
            check_value(mem_wen, 1'b0, "mem_wen during reset");
        end
        wait_reset_pc();

        if (!timed_out) begin
            for (int s = 0; s < num_steps; s++) begin
                @(posedge sys_clk);
                reset <= 1'b0;
                inst  <= prog_inst[s];
                @(negedge sys_clk);
                check_step(s);
            end
        end

        $display("mismatches: %0d, assertion failures: %0d", error_count,
                 i_rv_core.i_rv_core_checker.assert_fails);
        if (error_count == 0 && i_rv_core.i_rv_core_checker.assert_fails == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
